//--- lsu_pkg.sv
// ============================
// Load/store unit types
// ============================
package lsu_pkg;

    localparam int NUM_REGS     = 8;
    localparam int RCN_CREDITS  = 4;
    localparam int RETIRE_DEPTH = 3;

    typedef logic [31:0] word_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [3:0]  byte_mask_t;
    typedef logic [1:0]  ls_size_t;
    typedef logic [4:0]  ls_off_t;
    typedef logic [14:0] ls_op_t;
    typedef logic [$clog2(RCN_CREDITS + 1) - 1:0] credit_t;
    typedef word_t [NUM_REGS - 1:0] reg_file_t;

    localparam ls_size_t SZ_BYTE = 2'd0;
    localparam ls_size_t SZ_HALF = 2'd1;
    localparam ls_size_t SZ_WORD = 2'd2;
    localparam ls_size_t SZ_XCH  = 2'd3;

    // Op field layout: st, post, size[2], off[5], ptr[3], reg[3].
    function automatic logic op_store(ls_op_t op);
        return op[14];
    endfunction

    function automatic logic op_post_inc(ls_op_t op);
        return op[13];
    endfunction

    function automatic ls_size_t op_size(ls_op_t op);
        return op[12:11];
    endfunction

    function automatic ls_off_t op_off(ls_op_t op);
        return op[10:6];
    endfunction

    function automatic reg_idx_t op_ptr(ls_op_t op);
        return op[5:3];
    endfunction

    function automatic reg_idx_t op_reg(ls_op_t op);
        return op[2:0];
    endfunction

endpackage

//--- ls_req_if.sv
// ============================
// Formatted bus request
// ============================
`timescale 1ns/1ps

interface ls_req_if import lsu_pkg::*; ();

    logic     valid;
    logic     to_ring;
    logic     wr;
    logic     xch;
    word_t    addr;
    word_t    inc_addr;     // Pointer plus scaled offset.
    logic     ptr_wb;
    reg_idx_t ptr_reg;
    reg_idx_t wb_reg;
    word_t    wdata;
    byte_mask_t mask;

    modport addr_src (
        output valid, to_ring, wr, xch, addr, inc_addr, ptr_wb, ptr_reg, wb_reg
    );

    modport data_src (
        output wdata, mask
    );

    modport sink (
        input valid, to_ring, wr, xch, addr, inc_addr, ptr_wb, ptr_reg, wb_reg,
        input wdata, mask
    );

endinterface

//--- ls_addr_gen.sv
// ============================
// Address generation
// ============================
`timescale 1ns/1ps

module ls_addr_gen import lsu_pkg::*;
(
    input  reg_file_t regs,
    input  logic      dir_en,
    input  logic      dir_store,
    input  reg_idx_t  dir_reg,
    input  word_t     dir_addr,
    input  logic      op_en,
    input  ls_op_t    op,
    ls_req_if.addr_src req
);

    ls_size_t size;
    ls_off_t  off;
    word_t    ptr_aligned;
    word_t    off_scaled;
    word_t    inc_addr;

    assign size = op_size(op);
    assign off  = op_off(op);

    always_comb
    begin
        ptr_aligned = regs[op_ptr(op)];
        off_scaled  = {{25{off[4]}}, off, 2'b00};
        case (size)
            SZ_BYTE:
            begin
                off_scaled = {{27{off[4]}}, off};
            end
            SZ_HALF:
            begin
                ptr_aligned[0] = 1'b0;
                off_scaled = {{26{off[4]}}, off, 1'b0};
            end
            SZ_WORD, SZ_XCH:
            begin
                ptr_aligned[1:0] = 2'b00;
            end
        endcase
    end

    assign inc_addr = ptr_aligned + off_scaled;

    always_comb
    begin
        req.valid    = dir_en || op_en;
        req.inc_addr = inc_addr;
        req.ptr_reg  = op_ptr(op);
        if (dir_en)
        begin
            req.addr   = dir_addr;
            req.wr     = dir_store;
            req.xch    = 1'b0;
            req.wb_reg = dir_reg;
            req.ptr_wb = 1'b0;
        end
        else
        begin
            req.addr   = op_post_inc(op) ? ptr_aligned : inc_addr;
            req.wr     = op_store(op);
            req.xch    = op_store(op) && (size == SZ_XCH);
            req.wb_reg = op_reg(op);
            req.ptr_wb = op_en && op_post_inc(op);
        end
        req.to_ring = req.addr[31];     // Upper half of the map is the ring.
    end

endmodule

//--- ls_data_fmt.sv
// ============================
// Store data and byte mask
// ============================
`timescale 1ns/1ps

module ls_data_fmt import lsu_pkg::*;
(
    input  reg_file_t  regs,
    input  logic       dir_en,
    input  reg_idx_t   dir_reg,
    input  ls_op_t     op,
    input  logic [1:0] bus_addr_lo,
    ls_req_if.data_src req
);

    word_t src;

    assign src = dir_en ? regs[dir_reg] : regs[op_reg(op)];

    always_comb
    begin
        req.wdata = src;
        req.mask  = 4'b1111;    // Word, exchange and direct.
        if (!dir_en)
        begin
            case (op_size(op))
                SZ_BYTE:
                begin
                    req.wdata = {4{src[7:0]}};
                    req.mask  = byte_mask_t'(4'b0001 << bus_addr_lo);
                end
                SZ_HALF:
                begin
                    req.wdata = {2{src[15:0]}};
                    req.mask  = bus_addr_lo[1] ? 4'b1100 : 4'b0011;
                end
                default:
                begin
                    req.wdata = src;
                end
            endcase
        end
    end

endmodule

//--- ls_issue_retire.sv
// ============================
// Bus issue and writeback
// ============================
`timescale 1ns/1ps

module ls_issue_retire import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    ls_req_if.sink     req,
    input  word_t      din,
    input  logic       rcn_credit,
    output logic       ls_stall,
    output logic       dcs,
    output logic       dwr,
    output word_t      daddr,
    output byte_mask_t dmask,
    output word_t      dout,
    output logic       rcn_cs,
    output logic       rcn_xch,
    output logic       rcn_wr,
    output word_t      rcn_addr,
    output reg_idx_t   rcn_wbreg,
    output byte_mask_t rcn_mask,
    output word_t      rcn_wdata,
    output logic       ptr_wb_en,
    output reg_idx_t   ptr_wb_reg,
    output word_t      ptr_wb_data,
    output logic       ld_wb_en,
    output reg_idx_t   ld_wb_reg,
    output word_t      ld_wb_data
);

    localparam int LAST = RETIRE_DEPTH - 1;

    logic    accept;
    logic    data_issue;
    logic    ring_issue;
    credit_t credits;
    word_t   din_q;

    logic [RETIRE_DEPTH-1:0] ld_pipe;
    logic [RETIRE_DEPTH-1:0] ptr_pipe;
    reg_idx_t   ld_reg_pipe   [RETIRE_DEPTH];
    byte_mask_t mask_pipe     [RETIRE_DEPTH];
    reg_idx_t   ptr_reg_pipe  [RETIRE_DEPTH];
    word_t      ptr_addr_pipe [RETIRE_DEPTH];

    assign ls_stall   = req.valid && req.to_ring && (credits == '0);
    assign accept     = req.valid && !ls_stall;
    assign data_issue = accept && !req.to_ring;
    assign ring_issue = accept && req.to_ring;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dcs      <= 1'b0;
            rcn_cs   <= 1'b0;
            credits  <= credit_t'(RCN_CREDITS);
            ld_pipe  <= '0;
            ptr_pipe <= '0;
        end
        else
        begin
            dcs    <= data_issue;
            rcn_cs <= ring_issue;
            if (ring_issue && !rcn_credit)
                credits <= credits - 1'b1;
            else if (rcn_credit && !ring_issue)
                credits <= credits + 1'b1;
            // Exchanges return the old word too.
            ld_pipe  <= {ld_pipe[LAST-1:0], data_issue && (!req.wr || req.xch)};
            ptr_pipe <= {ptr_pipe[LAST-1:0], accept && req.ptr_wb};
        end
    end

    always_ff @(posedge clk)
    begin
        if (data_issue)
        begin
            dwr   <= req.wr;
            daddr <= req.addr;
            dmask <= req.mask;
            dout  <= req.wdata;
        end
        if (ring_issue)
        begin
            rcn_xch   <= req.xch;
            rcn_wr    <= req.wr;
            rcn_addr  <= req.addr;
            rcn_wbreg <= req.wb_reg;
            rcn_mask  <= req.mask;
            rcn_wdata <= req.wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        din_q            <= din;
        ld_reg_pipe[0]   <= req.wb_reg;
        mask_pipe[0]     <= req.mask;
        ptr_reg_pipe[0]  <= req.ptr_reg;
        ptr_addr_pipe[0] <= req.inc_addr;
        for (int i = 1; i < RETIRE_DEPTH; i++)
        begin
            ld_reg_pipe[i]   <= ld_reg_pipe[i-1];
            mask_pipe[i]     <= mask_pipe[i-1];
            ptr_reg_pipe[i]  <= ptr_reg_pipe[i-1];
            ptr_addr_pipe[i] <= ptr_addr_pipe[i-1];
        end
    end

    // Pick the lane named by the mask, zero-extended.
    always_comb
    begin
        case (mask_pipe[LAST])
            4'b0001: ld_wb_data = {24'd0, din_q[7:0]};
            4'b0010: ld_wb_data = {24'd0, din_q[15:8]};
            4'b0100: ld_wb_data = {24'd0, din_q[23:16]};
            4'b1000: ld_wb_data = {24'd0, din_q[31:24]};
            4'b0011: ld_wb_data = {16'd0, din_q[15:0]};
            4'b1100: ld_wb_data = {16'd0, din_q[31:16]};
            default: ld_wb_data = din_q;
        endcase
    end

    assign ld_wb_en    = ld_pipe[LAST];
    assign ld_wb_reg   = ld_reg_pipe[LAST];
    assign ptr_wb_en   = ptr_pipe[LAST];
    assign ptr_wb_reg  = ptr_reg_pipe[LAST];
    assign ptr_wb_data = ptr_addr_pipe[LAST];

endmodule

//--- ls_regfile.sv
// ============================
// Register file
// ============================
`timescale 1ns/1ps

module ls_regfile import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      host_wr_en,
    input  reg_idx_t  host_wr_reg,
    input  word_t     host_wr_data,
    input  reg_idx_t  host_rd_reg,
    output word_t     host_rd_data,
    input  logic      ptr_wb_en,
    input  reg_idx_t  ptr_wb_reg,
    input  word_t     ptr_wb_data,
    input  logic      ld_wb_en,
    input  reg_idx_t  ld_wb_reg,
    input  word_t     ld_wb_data,
    output reg_file_t regs
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            regs <= '0;
        end
        else
        begin
            // Later writes win on a shared target.
            if (host_wr_en)
                regs[host_wr_reg] <= host_wr_data;
            if (ptr_wb_en)
                regs[ptr_wb_reg] <= ptr_wb_data;
            if (ld_wb_en)
                regs[ld_wb_reg] <= ld_wb_data;
        end
    end

    assign host_rd_data = regs[host_rd_reg];

endmodule

//--- ls_unit.sv
// ============================
// Load/store unit top
// ============================
`timescale 1ns/1ps

module ls_unit import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       host_wr_en,
    input  reg_idx_t   host_wr_reg,
    input  word_t      host_wr_data,
    input  reg_idx_t   host_rd_reg,
    output word_t      host_rd_data,
    input  logic       ls_dir_en,
    input  logic       ls_dir_store,
    input  reg_idx_t   ls_dir_reg,
    input  word_t      ls_dir_addr,
    input  logic       ls_op_en,
    input  ls_op_t     ls_op,
    output logic       ls_stall,
    output logic       dcs,
    output logic       dwr,
    output word_t      daddr,
    output byte_mask_t dmask,
    output word_t      dout,
    input  word_t      din,
    output logic       rcn_cs,
    output logic       rcn_xch,
    output logic       rcn_wr,
    output word_t      rcn_addr,
    output reg_idx_t   rcn_wbreg,
    output byte_mask_t rcn_mask,
    output word_t      rcn_wdata,
    input  logic       rcn_credit
);

    reg_file_t regs;
    logic      ptr_wb_en;
    reg_idx_t  ptr_wb_reg;
    word_t     ptr_wb_data;
    logic      ld_wb_en;
    reg_idx_t  ld_wb_reg;
    word_t     ld_wb_data;

    ls_req_if req ();

    ls_regfile u_regfile (
        .clk(clk), .rst(rst),
        .host_wr_en(host_wr_en), .host_wr_reg(host_wr_reg), .host_wr_data(host_wr_data),
        .host_rd_reg(host_rd_reg), .host_rd_data(host_rd_data),
        .ptr_wb_en(ptr_wb_en), .ptr_wb_reg(ptr_wb_reg), .ptr_wb_data(ptr_wb_data),
        .ld_wb_en(ld_wb_en), .ld_wb_reg(ld_wb_reg), .ld_wb_data(ld_wb_data),
        .regs(regs)
    );

    ls_addr_gen u_addr_gen (
        .regs(regs), .dir_en(ls_dir_en), .dir_store(ls_dir_store),
        .dir_reg(ls_dir_reg), .dir_addr(ls_dir_addr),
        .op_en(ls_op_en), .op(ls_op), .req(req.addr_src)
    );

    ls_data_fmt u_data_fmt (
        .regs(regs), .dir_en(ls_dir_en), .dir_reg(ls_dir_reg), .op(ls_op),
        .bus_addr_lo(req.addr[1:0]), .req(req.data_src)
    );

    ls_issue_retire u_issue_retire (
        .clk(clk), .rst(rst), .req(req.sink), .din(din), .rcn_credit(rcn_credit),
        .ls_stall(ls_stall),
        .dcs(dcs), .dwr(dwr), .daddr(daddr), .dmask(dmask), .dout(dout),
        .rcn_cs(rcn_cs), .rcn_xch(rcn_xch), .rcn_wr(rcn_wr), .rcn_addr(rcn_addr),
        .rcn_wbreg(rcn_wbreg), .rcn_mask(rcn_mask), .rcn_wdata(rcn_wdata),
        .ptr_wb_en(ptr_wb_en), .ptr_wb_reg(ptr_wb_reg), .ptr_wb_data(ptr_wb_data),
        .ld_wb_en(ld_wb_en), .ld_wb_reg(ld_wb_reg), .ld_wb_data(ld_wb_data)
    );

endmodule

//--- tb_ls_unit.sv
// ============================
// Load/store unit testbench
// ============================
`timescale 1ns/1ps

module tb_ls_unit import lsu_pkg::*; ();

    logic       clk = 1'b0;
    logic       rst;
    logic       host_wr_en;
    reg_idx_t   host_wr_reg;
    word_t      host_wr_data;
    reg_idx_t   host_rd_reg;
    word_t      host_rd_data;
    logic       ls_dir_en;
    logic       ls_dir_store;
    reg_idx_t   ls_dir_reg;
    word_t      ls_dir_addr;
    logic       ls_op_en;
    ls_op_t     ls_op;
    logic       ls_stall;
    logic       dcs;
    logic       dwr;
    word_t      daddr;
    byte_mask_t dmask;
    word_t      dout;
    word_t      din;
    logic       rcn_cs;
    logic       rcn_xch;
    logic       rcn_wr;
    word_t      rcn_addr;
    reg_idx_t   rcn_wbreg;
    byte_mask_t rcn_mask;
    word_t      rcn_wdata;
    logic       rcn_credit;

    word_t mem [256];
    word_t exp_regs [NUM_REGS];
    word_t lcg_state = 32'h7dfd;
    logic  exp_ring;
    int    credits_m;
    logic  dcs_due;
    logic  rcn_due;
    int    errors = 0;
    int    test_base = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    // Expected response of the request in flight.
    word_t      x_addr;
    word_t      x_wdata;
    word_t      x_ptr_new;
    word_t      x_ld_data;
    word_t      x_mem_new;
    byte_mask_t x_mask;
    logic       x_wr;
    logic       x_xch;
    logic       x_ring;
    logic       x_ld;
    logic       x_ptr;
    reg_idx_t   x_wb_reg;
    reg_idx_t   x_ptr_reg;
    reg_idx_t   x_watch;

    ls_unit dut_i (.*);

    always #4 clk = ~clk;

    // Data memory, one cycle read latency.
    always @(posedge clk)
    begin
        if (dcs)
        begin
            din <= mem[daddr[9:2]];
            if (dwr)
                mem[daddr[9:2]] <= merge(mem[daddr[9:2]], dout, dmask);
        end
    end

    always @(posedge clk or posedge rst)
    begin : bus_monitor
        logic present;
        logic stall_m;
        logic take;
        present = ls_dir_en || ls_op_en;
        stall_m = present && exp_ring && (credits_m == 0);
        take    = present && !stall_m && exp_ring;
        if (rst)
        begin
            credits_m <= RCN_CREDITS;
            dcs_due   <= 1'b0;
            rcn_due   <= 1'b0;
        end
        else
        begin
            assert (ls_stall == stall_m)
                else fail_at("ls_stall differs from the credit model");
            assert (dcs == dcs_due)
                else fail_at("dcs not one cycle after a data bus accept");
            assert (rcn_cs == rcn_due)
                else fail_at("rcn_cs not one cycle after a ring accept");
            dcs_due   <= present && !stall_m && !exp_ring;
            rcn_due   <= take;
            credits_m <= credits_m + int'(rcn_credit) - int'(take);
        end
    end

    function automatic word_t rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t merge(input word_t old, input word_t data, input byte_mask_t m);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++)
            if (m[b])
                res[8*b +: 8] = data[8*b +: 8];
        return res;
    endfunction

    function automatic ls_op_t make_op(input logic st, input logic post, input ls_size_t size,
                                       input logic [4:0] off, input reg_idx_t ptr,
                                       input reg_idx_t rg);
        return {st, post, size, off, ptr, rg};
    endfunction

    task automatic fail_at(input string msg);
        $display("FAIL t=%0t %s", $time, msg);
        errors++;
    endtask

    task automatic abort(input string what);
        $display("Timeout: %s at t=%0t", what, $time);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_base)
            tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - test_base);
        test_base = errors;
    endtask

    task automatic host_write(input reg_idx_t r, input word_t v);
        @(posedge clk);
        host_wr_en   <= 1'b1;
        host_wr_reg  <= r;
        host_wr_data <= v;
        @(posedge clk);
        host_wr_en <= 1'b0;
        exp_regs[r] = v;
    endtask

    task automatic give_credit();
        @(posedge clk);
        rcn_credit <= 1'b1;
        @(posedge clk);
        rcn_credit <= 1'b0;
    endtask

    task automatic refill_credits();
        int missing;
        missing = RCN_CREDITS - credits_m;
        repeat (missing) give_credit();
    endtask

    task automatic start_req(input logic is_op, input logic st, input reg_idx_t r,
                             input word_t a, input ls_op_t op);
        ls_size_t sz;
        int       scale;
        word_t    base;
        word_t    d;
        word_t    old;
        @(posedge clk);
        sz        = is_op ? op[12:11] : SZ_WORD;
        scale     = (sz == SZ_BYTE) ? 1 : ((sz == SZ_HALF) ? 2 : 4);
        x_wb_reg  = is_op ? op[2:0] : r;
        x_ptr_reg = op[5:3];
        x_wr      = is_op ? op[14] : st;
        x_ptr     = is_op && op[13];
        x_xch     = is_op && x_wr && (sz == SZ_XCH);
        base      = exp_regs[x_ptr_reg] & ~(word_t'(scale) - 32'd1);
        x_ptr_new = base + word_t'($signed(op[10:6]) * scale);
        x_addr    = !is_op ? a : (x_ptr ? base : x_ptr_new);
        x_ring    = x_addr[31];
        d         = exp_regs[x_wb_reg];
        old       = mem[x_addr[9:2]];
        if (sz == SZ_BYTE)
        begin
            x_mask    = 4'b0001 << x_addr[1:0];
            x_wdata   = {4{d[7:0]}};
            x_ld_data = {24'd0, old[8*x_addr[1:0] +: 8]};
        end
        else if (sz == SZ_HALF)
        begin
            x_mask    = x_addr[1] ? 4'b1100 : 4'b0011;
            x_wdata   = {2{d[15:0]}};
            x_ld_data = {16'd0, old[16*x_addr[1] +: 16]};
        end
        else
        begin
            x_mask    = 4'b1111;
            x_wdata   = d;
            x_ld_data = old;
        end
        x_mem_new = merge(old, x_wdata, x_mask);
        x_ld      = !x_ring && (!x_wr || x_xch);
        x_watch   = x_ld ? x_wb_reg : x_ptr_reg;
        host_rd_reg  <= x_watch;
        ls_dir_en    <= !is_op;
        ls_dir_store <= st;
        ls_dir_reg   <= r;
        ls_dir_addr  <= a;
        ls_op_en     <= is_op;
        ls_op        <= op;
        exp_ring     <= x_ring;
    endtask

    task automatic compare_regs();
        for (int i = 0; i < NUM_REGS; i++)
        begin
            host_rd_reg <= reg_idx_t'(i);
            @(posedge clk);
            assert (host_rd_data == exp_regs[i])
                else fail_at($sformatf("r%0d is %h, expected %h", i, host_rd_data, exp_regs[i]));
        end
    endtask

    task automatic finish_req(input logic clash);
        int waited;
        waited = 0;
        @(posedge clk);
        while (ls_stall)
        begin
            waited++;
            if (waited > 40)
                abort("request never accepted");
            @(posedge clk);
        end
        ls_dir_en <= 1'b0;
        ls_op_en  <= 1'b0;
        @(posedge clk);
        if (x_ring)
        begin
            assert (rcn_addr == x_addr && rcn_wr == x_wr && rcn_xch == x_xch &&
                    rcn_wbreg == x_wb_reg)
                else fail_at($sformatf("ring request at %h, expected %h", rcn_addr, x_addr));
            assert (rcn_mask == x_mask && rcn_wdata == x_wdata)
                else fail_at($sformatf("ring mask %b data %h", rcn_mask, rcn_wdata));
        end
        else
        begin
            assert (daddr == x_addr && dwr == x_wr)
                else fail_at($sformatf("data bus address %h, expected %h", daddr, x_addr));
            assert (dmask == x_mask && dout == x_wdata)
                else fail_at($sformatf("data bus mask %b data %h", dmask, dout));
        end
        @(posedge clk);
        if (clash)
        begin
            host_wr_en   <= 1'b1;   // Lands on the load's edge.
            host_wr_reg  <= x_wb_reg;
            host_wr_data <= ~x_ld_data;
        end
        @(posedge clk);
        host_wr_en <= 1'b0;
        assert (host_rd_data == exp_regs[x_watch])
            else fail_at("register written before the third edge");
        if (!x_ring && x_wr)
            assert (mem[x_addr[9:2]] == x_mem_new)
                else fail_at($sformatf("memory word %h, expected %h", mem[x_addr[9:2]],
                                       x_mem_new));
        if (x_ptr)
            exp_regs[x_ptr_reg] = x_ptr_new;
        if (x_ld)
            exp_regs[x_wb_reg] = x_ld_data;
        @(posedge clk);
        assert (host_rd_data == exp_regs[x_watch])
            else fail_at($sformatf("r%0d is %h after writeback, expected %h", x_watch,
                                   host_rd_data, exp_regs[x_watch]));
        compare_regs();
    endtask

    task automatic dir_req(input logic st, input reg_idx_t r, input word_t a);
        start_req(1'b0, st, r, a, '0);
        finish_req(1'b0);
    endtask

    task automatic op_req(input ls_op_t op);
        start_req(1'b1, 1'b0, 3'd0, 32'd0, op);
        finish_req(1'b0);
    endtask

    initial
    begin : stimulus
        word_t a;
        rst          = 1'b1;
        host_wr_en   = 1'b0;
        host_wr_reg  = '0;
        host_wr_data = '0;
        host_rd_reg  = '0;
        ls_dir_en    = 1'b0;
        ls_dir_store = 1'b0;
        ls_dir_reg   = '0;
        ls_dir_addr  = '0;
        ls_op_en     = 1'b0;
        ls_op        = '0;
        din          = '0;
        rcn_credit   = 1'b0;
        exp_ring     = 1'b0;
        for (int i = 0; i < 256; i++)
            mem[i] = {8'(i), 8'(~i), 8'(i ^ 8'h5a), 8'(i * 7)};
        for (int i = 0; i < NUM_REGS; i++)
            exp_regs[i] = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        host_write(3'd1, rand_word());
        a = rand_word() & 32'h3fc;
        dir_req(1'b1, 3'd1, a);
        dir_req(1'b0, 3'd2, a);
        end_test("direct word store and load");

        host_write(3'd3, 32'h100 | (rand_word() & 32'hf0));
        host_write(3'd4, rand_word());
        for (int i = 0; i < 4; i++)
        begin
            op_req(make_op(1'b1, 1'b0, SZ_BYTE, 5'(i), 3'd3, 3'd4));
            op_req(make_op(1'b0, 1'b0, SZ_BYTE, 5'(i), 3'd3, 3'd5));
        end
        for (int i = 0; i < 2; i++)
        begin
            op_req(make_op(1'b1, 1'b0, SZ_HALF, 5'(i), 3'd3, 3'd4));
            op_req(make_op(1'b0, 1'b0, SZ_HALF, 5'(i + 4), 3'd3, 3'd6));
        end
        end_test("sub-word stores and loads");

        host_write(3'd3, 32'h200 | (rand_word() & 32'h7f));     // Unaligned pointer.
        op_req(make_op(1'b0, 1'b0, SZ_WORD, 5'(rand_word()), 3'd3, 3'd5));
        op_req(make_op(1'b1, 1'b1, SZ_HALF, 5'(rand_word()), 3'd3, 3'd4));
        op_req(make_op(1'b0, 1'b1, SZ_BYTE, 5'(rand_word()), 3'd3, 3'd6));
        op_req(make_op(1'b1, 1'b0, SZ_WORD, 5'h1c, 3'd3, 3'd4));
        op_req(make_op(1'b1, 1'b1, SZ_XCH, 5'h1f, 3'd3, 3'd6));
        end_test("offset and increment addressing");

        host_write(3'd7, 32'h8000_0000 | (rand_word() & 32'h00ff_fff0));
        dir_req(1'b1, 3'd4, 32'h8000_0000 | (rand_word() & 32'h0fff_fffc));
        op_req(make_op(1'b1, 1'b0, SZ_XCH, 5'd3, 3'd7, 3'd4));
        op_req(make_op(1'b1, 1'b0, SZ_BYTE, 5'd6, 3'd7, 3'd4));
        op_req(make_op(1'b0, 1'b0, SZ_HALF, 5'd1, 3'd7, 3'd5));
        refill_credits();
        end_test("ring routing");

        for (int i = 0; i < RCN_CREDITS; i++)
            dir_req(i[0], 3'd4, 32'h8000_1000 + 4 * i);
        for (int i = 0; i < 2; i++)
        begin
            start_req(1'b0, 1'b1, 3'd1, 32'hc000_0000 + 4 * i, '0);
            repeat (3)
            begin
                @(posedge clk);
                assert (ls_stall)
                    else fail_at("ring request not stalled with no credit left");
            end
            give_credit();
            finish_req(1'b0);
        end
        refill_credits();
        end_test("ring credit flow control");

        start_req(1'b0, 1'b0, 3'd5, rand_word() & 32'h3fc, '0);
        finish_req(1'b1);
        end_test("writeback priority");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- sim.f
lsu_pkg.sv
ls_req_if.sv
ls_addr_gen.sv
ls_data_fmt.sv
ls_issue_retire.sv
ls_regfile.sv
ls_unit.sv
tb_ls_unit.sv
